// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_sg_dma
FILELIST  = sources.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "ALL CHECKS PASSED" > /dev/null

clean:
	rm -rf obj_dir

// ==== design/sg_beat_fifo.sv ====
// beat FIFO between walker and output stream, room flag throttles the bus side
`timescale 1ns/1ps

module sg_beat_fifo #(
   parameter int FIFO_DEPTH  = 8,   // entries
   parameter int ROOM_MARGIN = 2    // room drops this far below full
) (
   input  logic                           wb_clk_i,
   input  logic                           wb_rst_i,
   input  logic                           beat_push_i,
   input  logic [sg_dma_pkg::DAT_W-1:0]   beat_data_i,
   output logic                           beat_room_o,
   output logic                           dout_req_o,
   output logic [sg_dma_pkg::DAT_W-1:0]   dout_data_o,
   input  logic                           dout_ack_i
);
   import sg_dma_pkg::*;

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   logic [DAT_W-1:0] mem [FIFO_DEPTH];   // storage
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;            // fill level
   logic             ack_q;              // ack delayed, edge detect
   logic             ack_rise;
   logic             pop;

   assign ack_rise    = dout_ack_i && !ack_q;
   assign pop         = dout_req_o && ack_rise;   // word taken by sink
   assign beat_room_o = (count_q < CNT_W'(FIFO_DEPTH - ROOM_MARGIN));
   assign dout_data_o = mem[rd_ptr_q];            // head, held while req is up

   always_ff @(posedge wb_clk_i) begin
      if (beat_push_i)
         mem[wr_ptr_q] <= beat_data_i;
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (beat_push_i)
            wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         if (pop)
            rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         case ({beat_push_i, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: ;   // both or neither, level holds
         endcase
      end
   end

   // four-phase output stage
   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         dout_req_o <= 1'b0;
         ack_q      <= 1'b0;
      end else begin
         ack_q <= dout_ack_i;
         if (pop)
            dout_req_o <= 1'b0;   // drop req with the pop
         else if (!dout_req_o && !dout_ack_i && !ack_q && count_q != '0)
            dout_req_o <= 1'b1;   // next word once ack is back low
      end
   end

   // walker must stop on the room flag before the fifo overflows
   a_no_push_full: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      beat_push_i |-> count_q < CNT_W'(FIFO_DEPTH));

endmodule

// ==== design/sg_cmd_regs.sv ====
// host side command register block with four-phase req/ack access, feeds the walker
`timescale 1ns/1ps

module sg_cmd_regs (
   input  logic                            wb_clk_i,
   input  logic                            wb_rst_i,
   input  logic                            host_req_i,
   input  logic                            host_we_i,
   input  logic [1:0]                      host_adr_i,
   input  logic [sg_dma_pkg::DAT_W-1:0]    host_dat_i,
   input  logic [sg_dma_pkg::DAT_W-1:0]    walk_status_i,
   output logic                            host_ack_o,
   output logic [sg_dma_pkg::DAT_W-1:0]    host_dat_o,
   output logic                            cmd_start_o,
   output logic                            cmd_clear_o,
   output logic [sg_dma_pkg::ADDR_W-4:0]   cmd_desc_o
);
   import sg_dma_pkg::*;

   logic [DAT_W-1:0]  limit_q;       // count limit, read back only
   logic [ADDR_W-4:0] desc_q;        // first descriptor, 64-bit word units
   logic              access;        // one cycle per handshake
   logic              walker_idle;
   logic [DAT_W-1:0]  rd_mux;

   assign access      = host_req_i && !host_ack_o;          // req seen, ack not yet up
   assign walker_idle = (walk_status_i[2:0] == ST_IDLE);
   assign cmd_desc_o  = desc_q;

   // read data select
   always_comb begin
      case (host_adr_i)
         REG_LIMIT:  rd_mux = limit_q;
         REG_DESC:   rd_mux = {desc_q, 3'b000};
         REG_START:  rd_mux = {{(DAT_W-1){1'b0}}, !walker_idle};   // busy flag
         default:    rd_mux = walk_status_i;
      endcase
   end

   // handshake and command registers
   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         host_ack_o  <= 1'b0;
         cmd_start_o <= 1'b0;
         cmd_clear_o <= 1'b0;
         limit_q     <= '0;
         desc_q      <= '0;
      end else begin
         host_ack_o  <= host_req_i;   // up one clock after req, down one after req drops
         cmd_start_o <= 1'b0;
         cmd_clear_o <= 1'b0;
         if (access && host_we_i) begin
            case (host_adr_i)
               REG_LIMIT: limit_q <= host_dat_i;
               REG_DESC:  desc_q  <= host_dat_i[ADDR_W-1:3];   // low bits ignored
               REG_START: begin
                  if (host_dat_i == '0)
                     cmd_clear_o <= 1'b1;        // zero clears end/panic
                  else if (walker_idle)
                     cmd_start_o <= 1'b1;        // refused while busy
               end
               default: ;                        // status is read only
            endcase
         end
      end
   end

   // read capture on the ack edge
   always_ff @(posedge wb_clk_i) begin
      if (access && !host_we_i)
         host_dat_o <= rd_mux;
   end

   // a req raised while ack is still up would never be answered
   a_req_after_ack: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      $rose(host_req_i) |-> !host_ack_o);

endmodule

// ==== design/sg_dma_pkg.sv ====
// shared widths, register map, walker states and status layout, imported by every engine stage
package sg_dma_pkg;

   localparam int ADDR_W = 32;   // byte address width
   localparam int DAT_W  = 32;   // each bus data half
   localparam int LEN_W  = 16;   // descriptor length field

   // host register indices
   localparam logic [1:0] REG_LIMIT  = 2'd0;   // word count limit, stored only
   localparam logic [1:0] REG_DESC   = 2'd1;   // first descriptor pointer
   localparam logic [1:0] REG_START  = 2'd2;   // non-zero starts, zero clears
   localparam logic [1:0] REG_STATUS = 2'd3;   // walker status, read only

   // walker FSM encoding, also reported in the error field
   typedef enum logic [2:0] {
      ST_IDLE     = 3'd0,   // waiting for start
      ST_CMD      = 3'd1,   // pointer latched
      ST_DESC_REQ = 3'd2,   // two descriptor beats
      ST_BUF_REQ  = 3'd3,   // buffer burst
      ST_BUF_WAIT = 3'd4,   // waiting for fifo room
      ST_NEXT     = 3'd5,   // pick next descriptor
      ST_END      = 3'd6,   // chain done
      ST_PANIC    = 3'd7    // bus error
   } walker_state_t;

   // status word: state 2:0, last 7, error 10:8, remaining length 31:16
   localparam int STAT_LAST_BIT = 7;
   localparam int STAT_ERR_LSB  = 8;

   // fields in the high word of descriptor beat 0
   localparam int DESC_LEN_LSB  = 3;    // length in bits 18:3
   localparam int DESC_LAST_BIT = 20;   // end of chain

endpackage

// ==== design/sg_dma_top.sv ====
// scatter-gather read DMA top, joins the register port, walker and beat FIFO
`timescale 1ns/1ps

module sg_dma_top #(
   parameter int FIFO_DEPTH  = 8,   // beat fifo entries
   parameter int ROOM_MARGIN = 2    // slack for the word on the stopping ack
) (
   input  logic                            wb_clk_i,
   input  logic                            wb_rst_i,
   // host register port
   input  logic                            host_req_i,
   input  logic                            host_we_i,
   input  logic [1:0]                      host_adr_i,
   input  logic [sg_dma_pkg::DAT_W-1:0]    host_dat_i,
   output logic                            host_ack_o,
   output logic [sg_dma_pkg::DAT_W-1:0]    host_dat_o,
   // wishbone master
   output logic                            wb_cyc_o,
   output logic                            wb_stb_o,
   output logic                            wb_we_o,
   output logic [sg_dma_pkg::ADDR_W-1:0]   wb_adr_o,
   input  logic [sg_dma_pkg::DAT_W-1:0]    wb_dat_i,
   input  logic [sg_dma_pkg::DAT_W-1:0]    wb_dat_hi_i,
   input  logic                            wb_ack_i,
   input  logic                            wb_rty_i,
   input  logic                            wb_err_i,
   // output stream
   output logic                            dout_req_o,
   output logic [sg_dma_pkg::DAT_W-1:0]    dout_data_o,
   input  logic                            dout_ack_i
);
   import sg_dma_pkg::*;

   logic              cmd_start;     // start pulse
   logic              cmd_clear;     // clear pulse
   logic [ADDR_W-4:0] cmd_desc;      // chain head
   logic [DAT_W-1:0]  walk_status;   // status back to host
   logic              beat_push;
   logic [DAT_W-1:0]  beat_data;
   logic              beat_room;     // fifo throttle

   sg_cmd_regs u_cmd_regs (
      .wb_clk_i      (wb_clk_i),
      .wb_rst_i      (wb_rst_i),
      .host_req_i    (host_req_i),
      .host_we_i     (host_we_i),
      .host_adr_i    (host_adr_i),
      .host_dat_i    (host_dat_i),
      .walk_status_i (walk_status),
      .host_ack_o    (host_ack_o),
      .host_dat_o    (host_dat_o),
      .cmd_start_o   (cmd_start),
      .cmd_clear_o   (cmd_clear),
      .cmd_desc_o    (cmd_desc)
   );

   sg_walker u_walker (
      .wb_clk_i      (wb_clk_i),
      .wb_rst_i      (wb_rst_i),
      .cmd_start_i   (cmd_start),
      .cmd_clear_i   (cmd_clear),
      .cmd_desc_i    (cmd_desc),
      .wb_cyc_o      (wb_cyc_o),
      .wb_stb_o      (wb_stb_o),
      .wb_we_o       (wb_we_o),
      .wb_adr_o      (wb_adr_o),
      .wb_dat_i      (wb_dat_i),
      .wb_dat_hi_i   (wb_dat_hi_i),
      .wb_ack_i      (wb_ack_i),
      .wb_rty_i      (wb_rty_i),
      .wb_err_i      (wb_err_i),
      .beat_room_i   (beat_room),
      .beat_push_o   (beat_push),
      .beat_data_o   (beat_data),
      .walk_status_o (walk_status)
   );

   sg_beat_fifo #(
      .FIFO_DEPTH  (FIFO_DEPTH),
      .ROOM_MARGIN (ROOM_MARGIN)
   ) u_beat_fifo (
      .wb_clk_i    (wb_clk_i),
      .wb_rst_i    (wb_rst_i),
      .beat_push_i (beat_push),
      .beat_data_i (beat_data),
      .beat_room_o (beat_room),
      .dout_req_o  (dout_req_o),
      .dout_data_o (dout_data_o),
      .dout_ack_i  (dout_ack_i)
   );

endmodule

// ==== design/sg_walker.sv ====
// descriptor chain walker, reads descriptors and buffers as a 64-bit wishbone classic master
`timescale 1ns/1ps

module sg_walker (
   input  logic                            wb_clk_i,
   input  logic                            wb_rst_i,
   input  logic                            cmd_start_i,
   input  logic                            cmd_clear_i,
   input  logic [sg_dma_pkg::ADDR_W-4:0]   cmd_desc_i,
   output logic                            wb_cyc_o,
   output logic                            wb_stb_o,
   output logic                            wb_we_o,
   output logic [sg_dma_pkg::ADDR_W-1:0]   wb_adr_o,
   input  logic [sg_dma_pkg::DAT_W-1:0]    wb_dat_i,
   input  logic [sg_dma_pkg::DAT_W-1:0]    wb_dat_hi_i,
   input  logic                            wb_ack_i,
   input  logic                            wb_rty_i,
   input  logic                            wb_err_i,
   input  logic                            beat_room_i,
   output logic                            beat_push_o,
   output logic [sg_dma_pkg::DAT_W-1:0]    beat_data_o,
   output logic [sg_dma_pkg::DAT_W-1:0]    walk_status_o
);
   import sg_dma_pkg::*;

   // control state
   walker_state_t     state_q, state_d;
   logic              cyc_q, cyc_d;     // cycle and strobe
   logic              cnt_q, cnt_d;     // descriptor beat select
   logic [2:0]        err_q, err_d;     // state that saw the error
   logic              last_q, last_d;   // last descriptor flag
   logic [LEN_W-1:0]  len_q, len_d;     // words left in buffer

   // payload
   logic [ADDR_W-1:0] adr_q, adr_d;     // bus address
   logic [ADDR_W-4:0] addr_q, addr_d;   // buffer pointer, word units
   logic [ADDR_W-4:0] next_q, next_d;   // next descriptor, word units
   logic [ADDR_W-4:0] addr_inc;

   assign addr_inc = addr_q + 1'b1;

   assign wb_cyc_o = cyc_q;
   assign wb_stb_o = cyc_q;   // classic, one strobe per cycle
   assign wb_we_o  = 1'b0;    // read engine only
   assign wb_adr_o = adr_q;

   // every buffer ack goes to the fifo
   assign beat_push_o = (state_q == ST_BUF_REQ) && cyc_q && wb_ack_i;
   assign beat_data_o = wb_dat_i;   // low half only

   // status word for the host
   always_comb begin
      walk_status_o                          = '0;
      walk_status_o[2:0]                     = state_q;
      walk_status_o[STAT_LAST_BIT]           = last_q;
      walk_status_o[STAT_ERR_LSB +: 3]       = err_q;
      walk_status_o[DAT_W-1 -: LEN_W]        = len_q;
   end

   always_comb begin
      state_d = state_q;
      cyc_d   = cyc_q;
      cnt_d   = cnt_q;
      err_d   = err_q;
      last_d  = last_q;
      len_d   = len_q;
      adr_d   = adr_q;
      addr_d  = addr_q;
      next_d  = next_q;

      case (state_q)
         ST_IDLE: begin
            if (cmd_start_i) begin
               next_d  = cmd_desc_i;   // chain head
               err_d   = '0;
               last_d  = 1'b0;
               len_d   = '0;
               state_d = ST_CMD;
            end
         end

         ST_CMD: begin
            adr_d   = {next_q, 3'b000};
            cyc_d   = 1'b1;
            cnt_d   = 1'b0;
            state_d = ST_DESC_REQ;
         end

         ST_DESC_REQ: begin
            if (!cyc_q) begin
               cyc_d = 1'b1;              // re-request after retry, same address
            end else if (wb_err_i) begin
               err_d   = state_q;
               cyc_d   = 1'b0;
               state_d = ST_PANIC;
            end else if (wb_rty_i) begin
               cyc_d = 1'b0;              // release the bus for a cycle
            end else if (wb_ack_i) begin
               if (!cnt_q) begin
                  // beat 0: length, last, buffer address
                  len_d  = wb_dat_hi_i[DESC_LEN_LSB +: LEN_W];
                  last_d = wb_dat_hi_i[DESC_LAST_BIT];
                  addr_d = wb_dat_i[ADDR_W-1:3];
                  cnt_d  = 1'b1;
                  adr_d  = adr_q + ADDR_W'(8);   // second beat, cyc stays up
               end else begin
                  // beat 1: next pointer
                  next_d = wb_dat_hi_i[ADDR_W-1:3];
                  cyc_d  = 1'b0;
                  if (len_q == '0)
                     state_d = ST_NEXT;        // empty buffer
                  else
                     state_d = ST_BUF_WAIT;
               end
            end
         end

         ST_BUF_REQ: begin
            if (wb_err_i) begin
               err_d   = state_q;
               cyc_d   = 1'b0;
               state_d = ST_PANIC;
            end else if (wb_rty_i) begin
               cyc_d   = 1'b0;            // buf_wait re-raises next clock
               state_d = ST_BUF_WAIT;
            end else if (wb_ack_i) begin
               addr_d = addr_inc;
               len_d  = len_q - 1'b1;
               adr_d  = {addr_inc, 3'b000};
               if (len_q == LEN_W'(1)) begin
                  cyc_d   = 1'b0;         // buffer done
                  state_d = ST_NEXT;
               end else if (!beat_room_i) begin
                  cyc_d   = 1'b0;         // this word taken, resume later
                  state_d = ST_BUF_WAIT;
               end
            end
         end

         ST_BUF_WAIT: begin
            if (beat_room_i) begin
               adr_d   = {addr_q, 3'b000};
               cyc_d   = 1'b1;
               state_d = ST_BUF_REQ;
            end
         end

         ST_NEXT: begin
            if (last_q) begin
               state_d = ST_END;
            end else begin
               adr_d   = {next_q, 3'b000};
               cyc_d   = 1'b1;
               cnt_d   = 1'b0;
               state_d = ST_DESC_REQ;
            end
         end

         ST_END, ST_PANIC: begin
            if (cmd_clear_i)
               state_d = ST_IDLE;   // host clear
         end

         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state_q <= ST_IDLE;
         cyc_q   <= 1'b0;
         cnt_q   <= 1'b0;
         err_q   <= '0;
         last_q  <= 1'b0;
         len_q   <= '0;
      end else begin
         state_q <= state_d;
         cyc_q   <= cyc_d;
         cnt_q   <= cnt_d;
         err_q   <= err_d;
         last_q  <= last_d;
         len_q   <= len_d;
      end
   end

   always_ff @(posedge wb_clk_i) begin
      adr_q  <= adr_d;
      addr_q <= addr_d;
      next_q <= next_d;
   end

   // a push needs a word still owed by the current buffer
   a_push_in_buf: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      beat_push_o |-> (len_q != '0));

   // retry releases the bus and keeps the beat address for the re-request
   a_rty_release: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      wb_cyc_o && wb_rty_i && !wb_err_i |=> !wb_cyc_o && $stable(wb_adr_o));

endmodule

// ==== sim/sg_testdata.txt ====
// 64-bit words, high half then low half, @ sets the word address
// words 00-2f memory image, from 30 command lines: mode, descriptor byte pointer, error byte address
@00
0000001800000080 0000001000000000   // desc 0: 3 words at 0x10, next desc 2
00000020000000a0 0000002000000000   // desc 2: 4 words at 0x14, next desc 4
00100010000000c0 0000000000000000   // desc 4: 2 words at 0x18, last
0000000000000000 0000004000000000   // desc 6: empty, next desc 8
00100028000000e0 0000000000000000   // desc 8: 5 words at 0x1c, last
@10
cafe0010a5000010 cafe0011a5000011 cafe0012a5000012
@14
cafe0014a5000014 cafe0015a5000015 cafe0016a5000016 cafe0017a5000017
@18
cafe0018a5000018 cafe0019a5000019
@1c
cafe001ca500001c cafe001da500001d cafe001ea500001e cafe001fa500001f cafe0020a5000020
// mode bit 0 slow sink, bit 1 bus retries and wait states, all ones ends the list
@30
00000000ffffffff   // three-descriptor chain, fast sink
00010000ffffffff   // same chain, sink slow enough to fill the fifo
00020030ffffffff   // empty descriptor then five words, random retries
00000000000000a8   // error on the second word of desc 2
00030000ffffffff   // restart after panic, slow sink and retries
ffffffffffffffff

// ==== sim/tb_sg_dma.sv ====
// testbench for the scatter-gather DMA, replays data file commands against a memory model
`timescale 1ns/1ps

module tb_sg_dma;
   import sg_dma_pkg::*;

   localparam int MEM_WORDS = 64;     // image plus command area
   localparam int CMD_BASE  = 48;     // first command line
   localparam int TIMEOUT   = 2000;   // limit for every wait loop

   logic        wb_clk_i;
   logic        wb_rst_i;
   logic        host_req_i;
   logic        host_we_i;
   logic [1:0]  host_adr_i;
   logic [31:0] host_dat_i;
   logic        host_ack_o;
   logic [31:0] host_dat_o;
   logic        wb_cyc_o;
   logic        wb_stb_o;
   logic        wb_we_o;
   logic [31:0] wb_adr_o;
   logic [31:0] wb_dat_i    = '0;     // memory model outputs
   logic [31:0] wb_dat_hi_i = '0;
   logic        wb_ack_i    = 1'b0;
   logic        wb_rty_i    = 1'b0;
   logic        wb_err_i    = 1'b0;
   logic        dout_req_o;
   logic [31:0] dout_data_o;
   logic        dout_ack_i;

   logic [63:0] image [MEM_WORDS];    // memory image and commands
   logic [31:0] exp_q [$];            // expected stream words
   logic [15:0] bus_lfsr  = 16'd51;
   logic [15:0] sink_lfsr = 16'd51;
   logic        slow_sink = 1'b0;     // mode bit 0
   logic        bus_noise = 1'b0;     // mode bit 1, retries and wait states
   logic [31:0] err_adr   = '1;       // all ones, no error beat

   sg_dma_top #(.FIFO_DEPTH(8), .ROOM_MARGIN(2)) dut (
      .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
      .host_req_i(host_req_i), .host_we_i(host_we_i), .host_adr_i(host_adr_i),
      .host_dat_i(host_dat_i), .host_ack_o(host_ack_o), .host_dat_o(host_dat_o),
      .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o), .wb_adr_o(wb_adr_o),
      .wb_dat_i(wb_dat_i), .wb_dat_hi_i(wb_dat_hi_i), .wb_ack_i(wb_ack_i),
      .wb_rty_i(wb_rty_i), .wb_err_i(wb_err_i),
      .dout_req_o(dout_req_o), .dout_data_o(dout_data_o), .dout_ack_i(dout_ack_i)
   );

   initial begin
      wb_clk_i = 1'b0;
      forever #50 wb_clk_i = ~wb_clk_i;   // 100 ns period
   end

   // fibonacci lfsr, taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic stop_failed();
      $display("CHECKS FAILED");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
         stop_failed();
      end
   endtask

   task automatic timed_out(input string what);
      $display("TIMEOUT at %0t: no progress while waiting for %s", $time, what);
      stop_failed();
   endtask

   // one four-phase register access
   task automatic reg_access(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
      int t;
      @(negedge wb_clk_i);
      host_we_i  = we;
      host_adr_i = adr;
      host_dat_i = wdat;
      host_req_i = 1'b1;
      t = 0;
      while (!host_ack_o) begin
         @(negedge wb_clk_i);
         t++;
         if (t > TIMEOUT) timed_out("host ack to rise");
      end
      rdat = host_dat_o;   // captured on the ack edge
      host_req_i = 1'b0;
      t = 0;
      while (host_ack_o) begin
         @(negedge wb_clk_i);
         t++;
         if (t > TIMEOUT) timed_out("host ack to fall");
      end
   endtask

   task automatic reg_write(input logic [1:0] adr, input logic [31:0] dat);
      logic [31:0] unused;
      reg_access(1'b1, adr, dat, unused);
   endtask

   task automatic reg_read(input logic [1:0] adr, output logic [31:0] dat);
      reg_access(1'b0, adr, '0, dat);
   endtask

   // walks the chain in the image, fills exp_q, returns the final status word
   task automatic build_expected(input logic [15:0] desc_byte, input logic [31:0] err_byte,
                                 output logic [31:0] exp_status);
      logic [28:0] ptr;
      logic [28:0] bufp;
      logic [28:0] w;
      logic [63:0] d0;
      logic [15:0] len;
      logic        last;
      logic        stop;
      int          i;
      int          hops;
      exp_q.delete();
      ptr  = {16'h0, desc_byte[15:3]};
      stop = 1'b0;
      hops = 0;
      exp_status = '0;
      while (!stop && hops < 16) begin
         d0   = image[ptr[5:0]];
         len  = d0[50:35];          // high word bits 18:3
         last = d0[52];             // high word bit 20
         bufp = d0[31:3];
         for (i = 0; i < int'(len) && !stop; i++) begin
            w = bufp + 29'(i);
            if ({w, 3'b000} == err_byte) begin
               exp_status = {len - 16'(i), 5'h0, 3'(ST_BUF_REQ), last, 4'h0, 3'(ST_PANIC)};
               stop = 1'b1;
            end else begin
               exp_q.push_back(image[w[5:0]][31:0]);   // low half only
            end
         end
         if (!stop && last) begin
            exp_status = {16'h0, 5'h0, 3'h0, 1'b1, 4'h0, 3'(ST_END)};
            stop = 1'b1;
         end
         ptr = image[ptr[5:0] + 6'd1][63:35];
         hops++;
      end
   endtask

   // output sink, takes n words and compares each with exp_q
   task automatic drain_stream(input int n);
      int k;
      int b;
      int d;
      int t;
      for (k = 0; k < n; k++) begin
         t = 0;
         while (!dout_req_o) begin
            @(negedge wb_clk_i);
            t++;
            if (t > TIMEOUT) timed_out("an output word");
         end
         sink_lfsr = lfsr_step(sink_lfsr);
         d = int'(sink_lfsr[0]);
         if (slow_sink) begin
            for (b = 0; b < 3; b++) begin
               sink_lfsr = lfsr_step(sink_lfsr);
               d = d * 2 + int'(sink_lfsr[0]);
            end
            d = d + 4;   // slow enough to fill the fifo
         end
         repeat (d) @(negedge wb_clk_i);
         check_value("dout_data_o", dout_data_o, exp_q.pop_front());
         dout_ack_i = 1'b1;
         t = 0;
         while (dout_req_o) begin
            @(negedge wb_clk_i);
            t++;
            if (t > TIMEOUT) timed_out("output req to fall");
         end
         dout_ack_i = 1'b0;
      end
   endtask

   // polls status until the walker reaches end or panic
   task automatic wait_finished();
      logic [31:0] st;
      int          t;
      t = 0;
      reg_read(REG_STATUS, st);
      while (st[2:0] != ST_END && st[2:0] != ST_PANIC) begin
         t++;
         if (t > TIMEOUT) timed_out("the chain to finish");
         reg_read(REG_STATUS, st);
      end
   endtask

   // command word: mode 63:48, descriptor byte pointer 47:32, error byte address 31:0
   task automatic run_command(input logic [63:0] cmd);
      logic [31:0] rd;
      logic [31:0] exp_status;
      int          n;
      slow_sink = cmd[48];
      bus_noise = cmd[49];
      err_adr   = cmd[31:0];
      build_expected(cmd[47:32], cmd[31:0], exp_status);
      n = exp_q.size();
      reg_write(REG_DESC, {16'h0, cmd[47:32]});
      reg_read(REG_DESC, rd);
      check_value("desc readback", rd, {16'h0, cmd[47:32]});
      reg_write(REG_START, 32'h1);
      fork
         drain_stream(n);
         wait_finished();
      join
      reg_read(REG_STATUS, rd);
      check_value("status", rd, exp_status);
      repeat (4) @(negedge wb_clk_i);   // room for a stray word to show up
      check_value("dout_req_o", 32'(dout_req_o), 32'h0);
      check_value("wb_cyc_o", 32'(wb_cyc_o), 32'h0);
      reg_write(REG_START, 32'h0);      // clear back to idle
      reg_read(REG_STATUS, rd);
      check_value("status state", 32'(rd[2:0]), 32'(ST_IDLE));
   endtask

   // wishbone memory, answers on the falling edge
   always @(negedge wb_clk_i) begin : mem_model
      logic hold;
      logic retry;
      wb_ack_i = 1'b0;
      wb_rty_i = 1'b0;
      wb_err_i = 1'b0;
      if (!wb_rst_i && wb_cyc_o) begin
         check_value("wb_adr_o[2:0]", 32'(wb_adr_o[2:0]), 32'h0);
         check_value("wb_we_o", 32'(wb_we_o), 32'h0);
         check_value("wb_stb_o", 32'(wb_stb_o), 32'h1);
         hold  = 1'b0;
         retry = 1'b0;
         if (bus_noise) begin
            bus_lfsr = lfsr_step(bus_lfsr);
            hold     = bus_lfsr[0];             // wait state
            bus_lfsr = lfsr_step(bus_lfsr);
            retry    = bus_lfsr[0];
            bus_lfsr = lfsr_step(bus_lfsr);
            retry    = retry & bus_lfsr[0];     // retry one beat in four
         end
         if (wb_adr_o == err_adr)
            wb_err_i = 1'b1;
         else if (retry)
            wb_rty_i = 1'b1;
         else if (!hold) begin
            wb_ack_i = 1'b1;
            {wb_dat_hi_i, wb_dat_i} = image[wb_adr_o[8:3]];
         end
      end
   end

   initial begin
      logic [31:0] rd;
      int          c;
      host_req_i = 1'b0;
      host_we_i  = 1'b0;
      host_adr_i = '0;
      host_dat_i = '0;
      dout_ack_i = 1'b0;
      wb_rst_i   = 1'b1;
      $readmemh("sim/sg_testdata.txt", image);
      repeat (10) @(posedge wb_clk_i);
      @(negedge wb_clk_i);
      wb_rst_i = 1'b0;
      check_value("wb_cyc_o", 32'(wb_cyc_o), 32'h0);
      check_value("wb_stb_o", 32'(wb_stb_o), 32'h0);
      check_value("host_ack_o", 32'(host_ack_o), 32'h0);
      check_value("dout_req_o", 32'(dout_req_o), 32'h0);
      reg_write(REG_LIMIT, 32'h1234abcd);
      reg_read(REG_LIMIT, rd);
      check_value("limit readback", rd, 32'h1234abcd);
      reg_read(REG_STATUS, rd);
      check_value("status state", 32'(rd[2:0]), 32'(ST_IDLE));
      c = CMD_BASE;
      while (c < MEM_WORDS && image[c] !== 64'hffffffffffffffff) begin
         run_command(image[c]);
         c++;
      end
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

// ==== sources.f ====
design/sg_dma_pkg.sv
design/sg_cmd_regs.sv
design/sg_walker.sv
design/sg_beat_fifo.sv
design/sg_dma_top.sv
sim/tb_sg_dma.sv
